/* common/cache_geom_pkg.sv */
// Data cache geometry
package cache_geom_pkg;

  // fixed cache shape
  localparam int num_ways       = 2;
  localparam int num_sets       = 8;
  localparam int words_per_line = 4;
  localparam int tag_bits       = 8;

  // derived index widths
  localparam int set_bits    = $clog2(num_sets);
  localparam int offset_bits = $clog2(words_per_line);

  // address tag held per line
  typedef logic [tag_bits-1:0] tag_t;

  // set number within a way
  typedef logic [set_bits-1:0] set_index_t;

  // word within a line
  typedef logic [offset_bits-1:0] block_offset_t;

  // full word address as seen by the read and store ports
  // tag on top, offset at the bottom
  typedef struct packed {
    tag_t          tag;
    set_index_t    set_index;
    block_offset_t block_offset;
  } cache_addr_t;

  // line address for fills, no word offset
  typedef struct packed {
    tag_t       tag;
    set_index_t set_index;
  } line_addr_t;

endpackage

/* common/cache_line_pkg.sv */
// Data cache line and victim types
package cache_line_pkg;

  import cache_geom_pkg::*;

  // data word width
  localparam int word_bits = 64;

  typedef logic [word_bits-1:0] word_t;

  // whole line, word 0 in the low bits
  typedef word_t [words_per_line-1:0] line_data_t;

  // way number
  typedef logic [$clog2(num_ways)-1:0] way_t;

  // line being replaced by a fill
  // handed to the memory side for write back
  typedef struct packed {
    logic       valid;
    logic       dirty;
    tag_t       tag;
    line_data_t data;
  } victim_t;

endpackage

/* dcache/dcache.sv */
// Two-way data cache top

`timescale 1ns/100ps

module dcache
  import cache_geom_pkg::*;
  import cache_line_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  // read ports
  input  cache_addr_t rd1_addr,
  input  cache_addr_t rd2_addr,
  // store port
  input  logic        store_en,
  input  cache_addr_t store_addr,
  input  word_t       store_data,
  // line fill port
  input  logic        fill_en,
  input  line_addr_t  fill_addr,
  input  line_data_t  fill_line,
  output logic        rd1_hit,
  output logic        rd2_hit,
  output logic        store_hit,
  output word_t       rd1_data,
  output word_t       rd2_data,
  output victim_t     victim
);

  // per-way results
  logic [num_ways-1:0]    rd1_hit_w;
  logic [num_ways-1:0]    rd2_hit_w;
  logic [num_ways-1:0]    store_hit_w;
  word_t [num_ways-1:0]   rd1_data_w;
  word_t [num_ways-1:0]   rd2_data_w;
  victim_t [num_ways-1:0] victim_w;

  // steered write strobes
  logic [num_ways-1:0] store_we_w;
  logic [num_ways-1:0] fill_we_w;

  // encoded hitting ways and the LRU pick
  way_t rd1_way;
  way_t rd2_way;
  way_t store_way;
  way_t lru_way;

  // one-hot hit vector to way number
  // at most one way hits, so OR-ing the indices is enough
  function automatic way_t hit_to_way(logic [num_ways-1:0] hits);
    way_t way;
    way = '0;
    for (int w = 0; w < num_ways; w++) begin
      if (hits[w]) begin
        way = way | way_t'(w);
      end
    end
    return way;
  endfunction

  assign rd1_way   = hit_to_way(rd1_hit_w);
  assign rd2_way   = hit_to_way(rd2_hit_w);
  assign store_way = hit_to_way(store_hit_w);

  // port level hits
  assign rd1_hit   = |rd1_hit_w;
  assign rd2_hit   = |rd2_hit_w;
  assign store_hit = |store_hit_w;

  // data from the hitting way, don't care on a miss
  assign rd1_data = rd1_data_w[rd1_way];
  assign rd2_data = rd2_data_w[rd2_way];

  // write back candidate lives in the LRU way
  assign victim = victim_w[lru_way];

  for (genvar w = 0; w < num_ways; w++) begin : g_way
    // store only where it hits, no write allocate
    assign store_we_w[w] = store_en && store_hit_w[w];
    // fill goes to the LRU way of the set
    assign fill_we_w[w]  = fill_en && (lru_way == way_t'(w));

    dcache_way u_way (
      .clock      (clock),
      .reset      (reset),
      .rd1_addr   (rd1_addr),
      .rd2_addr   (rd2_addr),
      .store_addr (store_addr),
      .store_data (store_data),
      .store_we   (store_we_w[w]),
      .fill_we    (fill_we_w[w]),
      .fill_addr  (fill_addr),
      .fill_line  (fill_line),
      .rd1_hit    (rd1_hit_w[w]),
      .rd2_hit    (rd2_hit_w[w]),
      .store_hit  (store_hit_w[w]),
      .rd1_data   (rd1_data_w[w]),
      .rd2_data   (rd2_data_w[w]),
      .victim     (victim_w[w])
    );
  end

  // every hit counts as a use of that way
  dcache_lru u_lru (
    .clock       (clock),
    .reset       (reset),
    .rd1_touch   (rd1_hit),
    .rd2_touch   (rd2_hit),
    .store_touch (store_en && store_hit),
    .fill_touch  (fill_en),
    .rd1_set     (rd1_addr.set_index),
    .rd2_set     (rd2_addr.set_index),
    .store_set   (store_addr.set_index),
    .rd1_way     (rd1_way),
    .rd2_way     (rd2_way),
    .store_way   (store_way),
    .fill_set    (fill_addr.set_index),
    .victim_way  (lru_way)
  );

endmodule

/* dcache/dcache_lru.sv */
// Data cache LRU state

`timescale 1ns/100ps

module dcache_lru
  import cache_geom_pkg::*;
  import cache_line_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  // touch strobes, one per event source
  input  logic       rd1_touch,
  input  logic       rd2_touch,
  input  logic       store_touch,
  input  logic       fill_touch,
  input  set_index_t rd1_set,
  input  set_index_t rd2_set,
  input  set_index_t store_set,
  input  way_t       rd1_way,
  input  way_t       rd2_way,
  input  way_t       store_way,
  input  set_index_t fill_set,
  output way_t       victim_way
);

  // one bit per set, names the next way to replace
  way_t [num_sets-1:0] lru_q;
  way_t [num_sets-1:0] lru_d;

  // a touched way makes the other one the victim
  // later events overwrite earlier ones on the same set
  always_comb begin
    lru_d = lru_q;
    // fill lands in the current victim way
    if (fill_touch) begin
      lru_d[fill_set] = ~lru_q[fill_set];
    end
    if (store_touch) begin
      lru_d[store_set] = ~store_way;
    end
    if (rd2_touch) begin
      lru_d[rd2_set] = ~rd2_way;
    end
    // rd1 has the last word
    if (rd1_touch) begin
      lru_d[rd1_set] = ~rd1_way;
    end
  end

  // state before the edge
  assign victim_way = lru_q[fill_set];

  always_ff @(posedge clock) begin
    if (reset) begin
      // way 0 goes first everywhere
      lru_q <= '0;
    end else begin
      lru_q <= lru_d;
    end
  end

endmodule

/* dcache/dcache_way.sv */
// Data cache way storage

`timescale 1ns/100ps

module dcache_way
  import cache_geom_pkg::*;
  import cache_line_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  // lookup addresses, shared with the other way
  input  cache_addr_t rd1_addr,
  input  cache_addr_t rd2_addr,
  input  cache_addr_t store_addr,
  input  word_t       store_data,
  // write strobes, already steered by the top
  input  logic        store_we,
  input  logic        fill_we,
  input  line_addr_t  fill_addr,
  input  line_data_t  fill_line,
  output logic        rd1_hit,
  output logic        rd2_hit,
  output logic        store_hit,
  output word_t       rd1_data,
  output word_t       rd2_data,
  output victim_t     victim
);

  // per-set state bits
  logic [num_sets-1:0] valid_q;
  logic [num_sets-1:0] dirty_q;

  // per-set tag and data arrays
  tag_t       tag_q  [num_sets];
  line_data_t data_q [num_sets];

  // line present and tag equal
  function automatic logic tag_match(cache_addr_t addr);
    return valid_q[addr.set_index] && (tag_q[addr.set_index] == addr.tag);
  endfunction

  // lookups are purely combinational
  assign rd1_hit   = tag_match(rd1_addr);
  assign rd2_hit   = tag_match(rd2_addr);
  assign store_hit = tag_match(store_addr);

  // word picked by block offset, meaningless on a miss
  assign rd1_data = data_q[rd1_addr.set_index][rd1_addr.block_offset];
  assign rd2_data = data_q[rd2_addr.set_index][rd2_addr.block_offset];

  // current contents of the fill set, before the fill lands
  always_comb begin
    victim.valid = valid_q[fill_addr.set_index];
    victim.dirty = dirty_q[fill_addr.set_index];
    victim.tag   = tag_q[fill_addr.set_index];
    victim.data  = data_q[fill_addr.set_index];
  end

  // valid and dirty bits
  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (fill_we) begin
      // fresh line from memory is clean
      valid_q[fill_addr.set_index] <= 1'b1;
      dirty_q[fill_addr.set_index] <= 1'b0;
    end else if (store_we) begin
      dirty_q[store_addr.set_index] <= 1'b1;
    end
  end

  // tag and data payload
  always_ff @(posedge clock) begin
    if (fill_we) begin
      tag_q[fill_addr.set_index]  <= fill_addr.tag;
      data_q[fill_addr.set_index] <= fill_line;
    end else if (store_we) begin
      // single word update, tag stays
      data_q[store_addr.set_index][store_addr.block_offset] <= store_data;
    end
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the data cache testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timescale 1ns/100ps --top-module dcache_tb \
  -Mdir "$BUILD_DIR" -o dcache_sim -f verilog.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/dcache_sim" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "STATUS: FAIL" "$LOG_FILE"; then
  echo "simulation reported failure"
  exit 1
fi

exit 0

/* test/dcache_tb.sv */
// Data cache testbench

`timescale 1ns/100ps

module dcache_tb
  import cache_geom_pkg::*;
  import cache_line_pkg::*;
;

  // DUT inputs
  logic        clock;
  logic        reset;
  cache_addr_t rd1_addr;
  cache_addr_t rd2_addr;
  logic        store_en;
  cache_addr_t store_addr;
  word_t       store_data;
  logic        fill_en;
  line_addr_t  fill_addr;
  line_data_t  fill_line;
  // DUT outputs
  logic        rd1_hit;
  logic        rd2_hit;
  logic        store_hit;
  word_t       rd1_data;
  word_t       rd2_data;
  victim_t     victim;

  // reference model state per way and set
  logic       m_valid [num_ways][num_sets];
  logic       m_dirty [num_ways][num_sets];
  tag_t       m_tag   [num_ways][num_sets];
  line_data_t m_data  [num_ways][num_sets];
  way_t       m_lru   [num_sets];

  int     error_count;
  int     test_count;
  int     test_fail;
  integer seed;

  dcache UUT (
    .clock      (clock),
    .reset      (reset),
    .rd1_addr   (rd1_addr),
    .rd2_addr   (rd2_addr),
    .store_en   (store_en),
    .store_addr (store_addr),
    .store_data (store_data),
    .fill_en    (fill_en),
    .fill_addr  (fill_addr),
    .fill_line  (fill_line),
    .rd1_hit    (rd1_hit),
    .rd2_hit    (rd2_hit),
    .store_hit  (store_hit),
    .rd1_data   (rd1_data),
    .rd2_data   (rd2_data),
    .victim     (victim)
  );

  // 40 ns clock
  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  task automatic report_mismatch(string name, logic [255:0] expected, logic [255:0] actual);
    error_count++;
    $display("[ERROR] time %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
  endtask

  function automatic cache_addr_t make_addr(tag_t t, set_index_t s, block_offset_t o);
    cache_addr_t a;
    a.tag = t;
    a.set_index = s;
    a.block_offset = o;
    return a;
  endfunction

  function automatic line_data_t make_line();
    line_data_t l;
    for (int i = 0; i < words_per_line; i++) begin
      l[i] = {$random(seed), $random(seed)};
    end
    return l;
  endfunction

  // model lookup over both ways
  function automatic logic model_lookup(input cache_addr_t a, output way_t way);
    logic hit;
    hit = 1'b0;
    way = '0;
    for (int w = 0; w < num_ways; w++) begin
      if (m_valid[w][a.set_index] && m_tag[w][a.set_index] == a.tag) begin
        hit = 1'b1;
        way = way_t'(w);
      end
    end
    return hit;
  endfunction

  function automatic logic tag_present(set_index_t s, tag_t t);
    return (m_valid[0][s] && m_tag[0][s] == t) || (m_valid[1][s] && m_tag[1][s] == t);
  endfunction

  // random address aimed at a resident line half the time
  function automatic cache_addr_t pick_addr();
    cache_addr_t a;
    logic [31:0] r;
    r = $random(seed);
    a = make_addr({6'b0, r[6:5]}, r[2:0], r[4:3]);
    if (r[7] && m_valid[r[8]][a.set_index]) begin
      a.tag = m_tag[r[8]][a.set_index];
    end
    return a;
  endfunction

  task automatic drive_idle();
    // parked read address that never gets filled
    rd1_addr = make_addr(8'hff, 3'd7, 2'd0);
    rd2_addr = make_addr(8'hff, 3'd7, 2'd0);
    store_en = 1'b0;
    fill_en  = 1'b0;
  endtask

  // check outputs mid cycle and advance the model over the edge
  task automatic step_cycle();
    logic h1;
    logic h2;
    logic hs;
    way_t w1;
    way_t w2;
    way_t ws;
    way_t fw;
    set_index_t fs;
    #10;
    h1 = model_lookup(rd1_addr, w1);
    h2 = model_lookup(rd2_addr, w2);
    hs = model_lookup(store_addr, ws);
    if (rd1_hit !== h1) report_mismatch("rd1_hit", 256'(h1), 256'(rd1_hit));
    if (h1 && rd1_data !== m_data[w1][rd1_addr.set_index][rd1_addr.block_offset])
      report_mismatch("rd1_data",
        256'(m_data[w1][rd1_addr.set_index][rd1_addr.block_offset]), 256'(rd1_data));
    if (rd2_hit !== h2) report_mismatch("rd2_hit", 256'(h2), 256'(rd2_hit));
    if (h2 && rd2_data !== m_data[w2][rd2_addr.set_index][rd2_addr.block_offset])
      report_mismatch("rd2_data",
        256'(m_data[w2][rd2_addr.set_index][rd2_addr.block_offset]), 256'(rd2_data));
    if (store_hit !== hs) report_mismatch("store_hit", 256'(hs), 256'(store_hit));
    fs = fill_addr.set_index;
    fw = m_lru[fs];
    if (fill_en) begin
      if (victim.valid !== m_valid[fw][fs])
        report_mismatch("victim.valid", 256'(m_valid[fw][fs]), 256'(victim.valid));
      if (victim.dirty !== m_dirty[fw][fs])
        report_mismatch("victim.dirty", 256'(m_dirty[fw][fs]), 256'(victim.dirty));
      // tag and data only mean something on a valid line
      if (m_valid[fw][fs] && victim.tag !== m_tag[fw][fs])
        report_mismatch("victim.tag", 256'(m_tag[fw][fs]), 256'(victim.tag));
      if (m_valid[fw][fs] && victim.data !== m_data[fw][fs])
        report_mismatch("victim.data", m_data[fw][fs], victim.data);
    end
    // events in order fill, store, rd2, rd1
    if (fill_en) begin
      m_valid[fw][fs] = 1'b1;
      m_dirty[fw][fs] = 1'b0;
      m_tag[fw][fs]   = fill_addr.tag;
      m_data[fw][fs]  = fill_line;
      m_lru[fs]       = ~fw;
    end
    if (store_en && hs) begin
      m_data[ws][store_addr.set_index][store_addr.block_offset] = store_data;
      m_dirty[ws][store_addr.set_index] = 1'b1;
      m_lru[store_addr.set_index] = ~ws;
    end
    if (h2) m_lru[rd2_addr.set_index] = ~w2;
    if (h1) m_lru[rd1_addr.set_index] = ~w1;
    @(negedge clock);
  endtask

  task automatic apply_reset();
    int n;
    reset = 1'b1;
    drive_idle();
    repeat (8) @(negedge clock);
    reset = 1'b0;
    for (int w = 0; w < num_ways; w++) begin
      for (int s = 0; s < num_sets; s++) begin
        m_valid[w][s] = 1'b0;
        m_dirty[w][s] = 1'b0;
        m_tag[w][s]   = '0;
        m_data[w][s]  = '0;
      end
    end
    for (int s = 0; s < num_sets; s++) m_lru[s] = '0;
    // bounded wait for clean hit outputs
    for (n = 0; n < 16; n++) begin
      if (rd1_hit === 1'b0 && rd2_hit === 1'b0 && store_hit === 1'b0) break;
      @(negedge clock);
    end
    if (n == 16) begin
      error_count++;
      $display("timeout: hit outputs did not settle to 0 after reset");
    end
  endtask

  task automatic fill_at(tag_t t, set_index_t s, line_data_t l);
    fill_en   = 1'b1;
    fill_addr = {t, s};
    fill_line = l;
    step_cycle();
    fill_en = 1'b0;
  endtask

  task automatic store_word(cache_addr_t a, word_t d);
    store_en   = 1'b1;
    store_addr = a;
    store_data = d;
    step_cycle();
    store_en = 1'b0;
  endtask

  task automatic read_pair(cache_addr_t a1, cache_addr_t a2);
    rd1_addr = a1;
    rd2_addr = a2;
    step_cycle();
    drive_idle();
  endtask

  task automatic close_test(string name, int errors_before);
    test_count++;
    if (error_count != errors_before) begin
      test_fail++;
      $display("%s: failed with %0d errors", name, error_count - errors_before);
    end else begin
      $display("%s: passed", name);
    end
  endtask

  // empty cache then one fill per set into invalid lines
  task automatic empty_after_reset();
    int e0;
    e0 = error_count;
    apply_reset();
    for (int s = 0; s < num_sets; s++) begin
      rd1_addr = make_addr(tag_t'($random(seed)), set_index_t'(s), 2'd0);
      rd2_addr = make_addr(tag_t'($random(seed)), set_index_t'(s), 2'd3);
      fill_at(tag_t'(s + 1), set_index_t'(s), make_line());
    end
    drive_idle();
    close_test("reset_state", e0);
  endtask

  task automatic fill_then_read_back();
    int e0;
    e0 = error_count;
    apply_reset();
    fill_at(8'h21, 3'd5, make_line());
    // every word on both ports with crossed offsets
    for (int o = 0; o < words_per_line; o++) begin
      read_pair(make_addr(8'h21, 3'd5, block_offset_t'(o)),
                make_addr(8'h21, 3'd5, block_offset_t'(3 - o)));
    end
    read_pair(make_addr(8'h22, 3'd5, 2'd0), make_addr(8'h21, 3'd4, 2'd1));
    close_test("fill_readback", e0);
  endtask

  task automatic store_hit_and_miss();
    int e0;
    e0 = error_count;
    apply_reset();
    fill_at(8'h33, 3'd2, make_line());
    store_word(make_addr(8'h33, 3'd2, 2'd1), {$random(seed), $random(seed)});
    read_pair(make_addr(8'h33, 3'd2, 2'd0), make_addr(8'h33, 3'd2, 2'd1));
    read_pair(make_addr(8'h33, 3'd2, 2'd2), make_addr(8'h33, 3'd2, 2'd3));
    // store to an absent line allocates nothing
    store_word(make_addr(8'h34, 3'd2, 2'd1), {$random(seed), $random(seed)});
    read_pair(make_addr(8'h33, 3'd2, 2'd0), make_addr(8'h33, 3'd2, 2'd1));
    read_pair(make_addr(8'h34, 3'd2, 2'd1), make_addr(8'h33, 3'd2, 2'd3));
    close_test("store", e0);
  endtask

  task automatic evict_after_read(logic with_store);
    int e0;
    line_data_t lb;
    line_data_t eb;
    word_t sd;
    e0 = error_count;
    apply_reset();
    lb = make_line();
    sd = {$random(seed), $random(seed)};
    eb = lb;
    fill_at(8'h41, 3'd3, make_line());
    fill_at(8'h42, 3'd3, lb);
    // store before the read so line b stays the LRU pick
    if (with_store) begin
      store_word(make_addr(8'h42, 3'd3, 2'd2), sd);
      eb[2] = sd;
    end
    read_pair(make_addr(8'h41, 3'd3, 2'd0), make_addr(8'hff, 3'd7, 2'd0));
    fill_en   = 1'b1;
    fill_addr = {8'h43, 3'd3};
    fill_line = make_line();
    #5;
    if (victim.valid !== 1'b1) report_mismatch("victim.valid", 256'(1), 256'(victim.valid));
    if (victim.tag !== 8'h42) report_mismatch("victim.tag", 256'(8'h42), 256'(victim.tag));
    if (victim.dirty !== with_store)
      report_mismatch("victim.dirty", 256'(with_store), 256'(victim.dirty));
    if (victim.data !== eb) report_mismatch("victim.data", eb, victim.data);
    step_cycle();
    fill_en = 1'b0;
    close_test(with_store ? "victim_dirty" : "victim_clean", e0);
  endtask

  task automatic random_traffic();
    int e0;
    logic [31:0] r;
    tag_t t;
    e0 = error_count;
    apply_reset();
    for (int i = 0; i < 200; i++) begin
      rd1_addr = pick_addr();
      rd2_addr = pick_addr();
      r = $random(seed);
      if (r[1:0] == 2'd1) begin
        store_en   = 1'b1;
        store_addr = pick_addr();
        store_data = {$random(seed), $random(seed)};
      end else if (r[1:0] == 2'd2) begin
        // find a tag from the small pool that is not in the set
        for (int k = 0; k < 16; k++) begin
          t = tag_t'($random(seed) & 3);
          if (!tag_present(r[4:2], t)) break;
        end
        if (!tag_present(r[4:2], t)) begin
          fill_en   = 1'b1;
          fill_addr = {t, r[4:2]};
          fill_line = make_line();
        end
      end
      step_cycle();
      store_en = 1'b0;
      fill_en  = 1'b0;
    end
    drive_idle();
    close_test("random", e0);
  endtask

  initial begin
    seed        = 32'ha54b3677;
    error_count = 0;
    test_count  = 0;
    test_fail   = 0;
    reset       = 1'b1;
    store_addr  = '0;
    store_data  = '0;
    fill_addr   = '0;
    fill_line   = '0;
    drive_idle();
    empty_after_reset();
    fill_then_read_back();
    store_hit_and_miss();
    evict_after_read(1'b0);
    evict_after_read(1'b1);
    random_traffic();
    $display("tests run: %0d, failed: %0d, errors: %0d", test_count, test_fail, error_count);
    if (error_count == 0 && test_fail == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* verilog.f */
common/cache_geom_pkg.sv
common/cache_line_pkg.sv
dcache/dcache_way.sv
dcache/dcache_lru.sv
dcache/dcache.sv
test/dcache_tb.sv
